// ==== source/vmem_pkg.sv ====
package vmem_pkg;

    localparam int num_lanes  = 4;
    localparam int ram_words  = 256;
    localparam int ram_addr_w = 8;
    localparam int vreg_bytes = 16;   // Four 32-bit banks

    typedef enum logic [1:0] {
        eew8  = 2'd0,
        eew16 = 2'd1,
        eew32 = 2'd2
    } eew_e;

    // One element word, read whole, as halves or as bytes
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } elem_word_u;

    typedef struct packed {
        logic                       is_vector;
        logic                       is_store;
        eew_e                       eew;
        logic [31:0]                base;
        logic [31:0]                stride;      // Byte stride
        logic [1:0]                 uop_num;
        logic [3:0]                 vstart;
        logic [num_lanes-1:0]       lane_mask;
        logic [num_lanes-1:0][31:0] store_data;  // Scalar uses word 0
        logic [4:0]                 vd;
        logic [4:0]                 rd;
    } vmem_req_t;

    typedef struct packed {
        vmem_req_t            req;
        logic [num_lanes-1:0] elem_mask;
    } vmem_uop_t;

    typedef struct packed {
        logic                         valid;
        logic                         wen;
        logic [ram_addr_w-1:0]        word_addr;
        logic [3:0]                   byte_en;
        logic [31:0]                  wdata;
        eew_e                         size;
        logic                         is_signed;
        logic [$clog2(num_lanes)-1:0] lane;
        logic                         last;
    } mem_access_t;

    typedef struct packed {
        logic                         valid;
        logic [31:0]                  rdata;   // Already extended
        logic [$clog2(num_lanes)-1:0] lane;
        logic                         last;
    } mem_reply_t;

    typedef struct packed {
        logic                       is_vector;
        logic [4:0]                 vd;
        logic [num_lanes-1:0][31:0] vwdata;
        logic [num_lanes-1:0][3:0]  vbyte_wen;
        logic                       reg_write;
        logic [4:0]                 rd;
        logic [31:0]                rdata;
        logic                       mal_addr;
    } vmem_resp_t;

endpackage

// ==== source/vmem_uop_decode.sv ====
`timescale 1ns/1ps

module vmem_uop_decode (
    input  logic                CLK,
    input  logic                reset,
    input  logic                req_valid,
    input  vmem_pkg::vmem_req_t req,
    input  logic                done,
    output logic                start,
    output vmem_pkg::vmem_uop_t uop,
    output logic                busy
);

    import vmem_pkg::*;

    logic                 busy_q;
    logic                 accept;
    logic [num_lanes-1:0] elem_mask;

    // Busy already low in the response cycle
    assign busy   = busy_q & ~done;
    assign accept = req_valid & ~busy;

    // Element mask from lane mask and vstart
    always_comb begin
        elem_mask = '0;
        if (req.is_vector) begin
            for (int l = 0; l < num_lanes; l++) begin
                // Element index is uop_num * 4 + lane
                elem_mask[l] = req.lane_mask[l] & ({req.uop_num, 2'(l)} >= req.vstart);
            end
        end else begin
            elem_mask[0] = 1'b1;  // Scalar access on lane 0
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            busy_q <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Op held until the response has gone out
    always_ff @(posedge CLK) begin
        if (accept) begin
            uop.req       <= req;
            uop.elem_mask <= elem_mask;
        end
    end

endmodule

// ==== source/vmem_serializer.sv ====
`timescale 1ns/1ps

module vmem_serializer (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  start,
    input  vmem_pkg::vmem_uop_t   uop,
    output vmem_pkg::mem_access_t access,
    output logic                  mal_addr
);

    import vmem_pkg::*;

    logic                         running;
    logic [$clog2(num_lanes)-1:0] lane_q;
    logic [$clog2(num_lanes)-1:0] cur_lane;
    logic                         step;
    logic                         active;
    logic                         aligned;
    logic                         mal_now;
    logic [31:0]                  elem_addr;
    logic [31:0]                  lane_data;
    mem_access_t                  access_d;

    // Lane 0 goes out in the start cycle itself
    assign step     = start | running;
    assign cur_lane = start ? '0 : lane_q;
    assign active   = step & uop.elem_mask[cur_lane];
    assign mal_now  = active & ~aligned;

    always_comb begin
        if (uop.req.is_vector) begin
            elem_addr = uop.req.base + uop.req.stride * 32'(cur_lane);
        end else begin
            elem_addr = uop.req.base;
        end
    end

    always_comb begin
        case (uop.req.eew)
            eew8:    aligned = 1'b1;
            eew16:   aligned = ~elem_addr[0];
            default: aligned = (elem_addr[1:0] == 2'b00);
        endcase
    end

    always_comb begin
        access_d  = '0;
        lane_data = uop.req.store_data[cur_lane];
        if (step) begin
            access_d.valid     = active & aligned;   // Skipped lanes stay invalid
            access_d.wen       = uop.req.is_store;
            access_d.word_addr = elem_addr[ram_addr_w+1:2];
            case (uop.req.eew)
                eew8:    access_d.byte_en = 4'(4'b0001 << elem_addr[1:0]);
                eew16:   access_d.byte_en = 4'(4'b0011 << elem_addr[1:0]);
                default: access_d.byte_en = 4'b1111;
            endcase
            access_d.wdata     = lane_data << {elem_addr[1:0], 3'b000};
            access_d.size      = uop.req.eew;
            access_d.is_signed = ~uop.req.is_vector;  // Vector loads zero-extend
            access_d.lane      = cur_lane;
            access_d.last      = ~uop.req.is_vector | (&cur_lane);
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            running  <= 1'b0;
            lane_q   <= '0;
            mal_addr <= 1'b0;
            access   <= '0;
        end else begin
            access <= access_d;
            if (start) begin
                running  <= uop.req.is_vector;
                lane_q   <= 1;
                mal_addr <= mal_now;   // Fresh flag per op
            end else if (running) begin
                lane_q   <= lane_q + 1'b1;
                running  <= ~(&lane_q);
                mal_addr <= mal_addr | mal_now;
            end
        end
    end

endmodule

// ==== source/vmem_data_ram.sv ====
`timescale 1ns/1ps

module vmem_data_ram (
    input  logic                  CLK,
    input  logic                  reset,
    input  vmem_pkg::mem_access_t access,
    output vmem_pkg::mem_reply_t  reply
);

    import vmem_pkg::*;

    logic [31:0] mem [ram_words];
    elem_word_u  rd_word;
    logic [1:0]  elem_off;
    logic [31:0] elem_ext;

    always_comb begin
        rd_word.word = mem[access.word_addr];

        // Lowest enabled byte marks the element position
        casez (access.byte_en)
            4'b???1: elem_off = 2'd0;
            4'b??10: elem_off = 2'd1;
            4'b?100: elem_off = 2'd2;
            default: elem_off = 2'd3;
        endcase

        case (access.size)
            eew8: begin
                elem_ext = {24'h0, rd_word.bytes[elem_off]};
                if (access.is_signed) begin
                    elem_ext[31:8] = {24{rd_word.bytes[elem_off][7]}};
                end
            end
            eew16: begin
                elem_ext = {16'h0, rd_word.half[elem_off[1]]};
                if (access.is_signed) begin
                    elem_ext[31:16] = {16{rd_word.half[elem_off[1]][15]}};
                end
            end
            default: elem_ext = rd_word.word;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int w = 0; w < ram_words; w++) begin
                mem[w] <= '0;
            end
            reply <= '0;
        end else begin
            if (access.valid && access.wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (access.byte_en[b]) begin
                        mem[access.word_addr][8*b +: 8] <= access.wdata[8*b +: 8];
                    end
                end
            end
            reply.valid <= access.valid & ~access.wen;  // Only loads reply with data
            reply.rdata <= elem_ext;
            reply.lane  <= access.lane;
            reply.last  <= access.last;
        end
    end

endmodule

// ==== source/vmem_writeback.sv ====
`timescale 1ns/1ps

module vmem_writeback (
    input  logic                 CLK,
    input  logic                 reset,
    input  vmem_pkg::vmem_uop_t  uop,
    input  vmem_pkg::mem_reply_t reply,
    input  logic                 mal_addr,
    output logic                 resp_valid,
    output vmem_pkg::vmem_resp_t resp,
    output logic                 done
);

    import vmem_pkg::*;

    logic [num_lanes-1:0][31:0]    acc_data;
    logic [num_lanes-1:0][31:0]    acc_data_d;
    logic [num_lanes-1:0][3:0]     acc_ben;
    logic [num_lanes-1:0][3:0]     acc_ben_d;
    logic [31:0]                   sc_data;
    logic [31:0]                   sc_data_d;
    logic                          sc_wr;
    logic                          sc_wr_d;
    logic [$clog2(vreg_bytes)-1:0] elem_idx;
    logic [$clog2(vreg_bytes)-1:0] byte_off;
    elem_word_u                    lane_word;
    elem_word_u                    placed;
    logic [3:0]                    ben;

    assign done = resp_valid;

    always_comb begin
        elem_idx       = {uop.req.uop_num, reply.lane};
        lane_word.word = reply.rdata;
        placed.word    = '0;
        // Register byte offset, wraps at 16
        case (uop.req.eew)
            eew8: begin
                byte_off                     = elem_idx;
                placed.bytes[byte_off[1:0]] = lane_word.bytes[0];
                ben                          = 4'(4'b0001 << byte_off[1:0]);
            end
            eew16: begin
                byte_off                = elem_idx << 1;
                placed.half[byte_off[1]] = lane_word.half[0];
                ben                     = 4'(4'b0011 << byte_off[1:0]);
            end
            default: begin
                byte_off    = elem_idx << 2;
                placed.word = lane_word.word;
                ben         = 4'b1111;
            end
        endcase

        acc_data_d = acc_data;
        acc_ben_d  = acc_ben;
        sc_data_d  = sc_data;
        sc_wr_d    = sc_wr;
        if (reply.valid) begin
            if (uop.req.is_vector) begin
                acc_data_d[byte_off[$clog2(vreg_bytes)-1:2]] |= placed.word;
                acc_ben_d[byte_off[$clog2(vreg_bytes)-1:2]]  |= ben;
            end else begin
                sc_data_d = reply.rdata;  // Sign-extended by the RAM
                sc_wr_d   = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            resp_valid <= 1'b0;
            acc_data   <= '0;
            acc_ben    <= '0;
            sc_data    <= '0;
            sc_wr      <= 1'b0;
        end else begin
            resp_valid <= reply.last;
            if (reply.last) begin
                acc_data <= '0;
                acc_ben  <= '0;
                sc_data  <= '0;
                sc_wr    <= 1'b0;
            end else begin
                acc_data <= acc_data_d;
                acc_ben  <= acc_ben_d;
                sc_data  <= sc_data_d;
                sc_wr    <= sc_wr_d;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (reply.last) begin
            resp.is_vector <= uop.req.is_vector;
            resp.vd        <= uop.req.vd;
            resp.vwdata    <= acc_data_d;
            resp.vbyte_wen <= acc_ben_d;
            resp.reg_write <= sc_wr_d;
            resp.rd        <= uop.req.rd;
            resp.rdata     <= sc_data_d;
            resp.mal_addr  <= mal_addr;
        end
    end

endmodule

// ==== source/vmem_stage.sv ====
`timescale 1ns/1ps

module vmem_stage (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 req_valid,
    input  vmem_pkg::vmem_req_t  req,
    output logic                 busy,
    output logic                 resp_valid,
    output vmem_pkg::vmem_resp_t resp
);

    import vmem_pkg::*;

    vmem_uop_t   uop;
    mem_access_t access;
    mem_reply_t  reply;
    logic        start;
    logic        done;
    logic        mal_addr;

    vmem_uop_decode u_decode (
        .CLK,
        .reset,
        .req_valid,
        .req,
        .done,
        .start,
        .uop,
        .busy
    );

    // One lane access per cycle
    vmem_serializer u_serializer (
        .CLK,
        .reset,
        .start,
        .uop,
        .access,
        .mal_addr
    );

    vmem_data_ram u_ram (
        .CLK,
        .reset,
        .access,
        .reply
    );

    vmem_writeback u_writeback (
        .CLK,
        .reset,
        .uop,
        .reply,
        .mal_addr,
        .resp_valid,
        .resp,
        .done
    );

endmodule

// ==== bench/vmem_stage_properties.sv ====
`timescale 1ns/1ps

module vmem_stage_properties (
    input logic                CLK,
    input logic                reset,
    input logic                req_valid,
    input vmem_pkg::vmem_req_t req,
    input logic                busy,
    input logic                resp_valid
);

    int   fail_count = 0;
    logic accept;

    assign accept = req_valid & ~busy;

    // Scalar ops answer after three edges
    scalar_latency: assert property (@(posedge CLK) disable iff (reset)
        accept && !req.is_vector |=> !resp_valid [*3] ##1 resp_valid)
        else begin
            fail_count++;
            $error("scalar response not exactly 3 cycles after the request");
        end

    vector_latency: assert property (@(posedge CLK) disable iff (reset)
        accept && req.is_vector |=> !resp_valid [*6] ##1 resp_valid)  // Four lanes plus pipe
        else begin
            fail_count++;
            $error("vector response not exactly 6 cycles after the request");
        end

    resp_single_cycle: assert property (@(posedge CLK) disable iff (reset)
        resp_valid |=> !resp_valid)
        else begin
            fail_count++;
            $error("resp_valid held longer than one cycle");
        end

    reset_idle: assert property (@(posedge CLK)
        reset |=> !busy && !resp_valid)
        else begin
            fail_count++;
            $error("busy or resp_valid high after reset");
        end

    no_req_when_busy: assert property (@(posedge CLK) disable iff (reset)
        req_valid |-> !busy)
        else begin
            fail_count++;
            $error("req_valid raised while busy");
        end

endmodule

bind vmem_stage vmem_stage_properties u_properties (
    .CLK,
    .reset,
    .req_valid,
    .req,
    .busy,
    .resp_valid
);

// ==== bench/vmem_stage_checker.sv ====
`timescale 1ns/1ps

module vmem_stage_checker (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 req_valid,
    input  vmem_pkg::vmem_req_t  req,
    input  logic                 busy,
    input  logic                 resp_valid,
    input  vmem_pkg::vmem_resp_t resp,
    output int                   mismatch_count,
    output int                   other_count,
    output int                   resp_count
);

    import vmem_pkg::*;

    logic [7:0] model_mem [1024];  // Byte image of the 1 KB address space
    vmem_resp_t expected;
    logic       pending;

    // Applies one op to the memory image and builds its response
    task automatic run_model(input vmem_req_t r, output vmem_resp_t e);
        int          esize;
        int          lanes;
        int          elem;
        int          off;
        logic [31:0] addr;
        logic [31:0] value;
        logic        active;
        e           = '0;
        e.is_vector = r.is_vector;
        e.vd        = r.vd;
        e.rd        = r.rd;
        esize       = 1 << int'(r.eew);
        lanes       = r.is_vector ? num_lanes : 1;
        for (int l = 0; l < lanes; l++) begin
            elem   = int'(r.uop_num) * 4 + l;
            addr   = r.is_vector ? r.base + r.stride * 32'(l) : r.base;
            active = !r.is_vector || (r.lane_mask[l] && elem >= int'(r.vstart));
            if (active && (addr % 32'(esize)) != 0) begin
                e.mal_addr = 1'b1;  // Skipped, memory untouched
            end else if (active) begin
                value = '0;
                for (int b = 0; b < esize; b++) begin
                    if (r.is_store) begin
                        model_mem[10'(addr + 32'(b))] = r.store_data[l][8*b +: 8];
                    end else begin
                        value[8*b +: 8] = model_mem[10'(addr + 32'(b))];
                    end
                end
                if (!r.is_store && r.is_vector) begin
                    off = (elem * esize) % vreg_bytes;
                    for (int b = 0; b < esize; b++) begin
                        e.vwdata[(off + b) / 4][8*((off + b) % 4) +: 8] = value[8*b +: 8];
                        e.vbyte_wen[(off + b) / 4][(off + b) % 4]       = 1'b1;
                    end
                end else if (!r.is_store) begin
                    if (esize == 1) begin
                        value = {{24{value[7]}}, value[7:0]};
                    end else if (esize == 2) begin
                        value = {{16{value[15]}}, value[15:0]};
                    end
                    e.rdata     = value;
                    e.reg_write = 1'b1;
                end
            end
        end
    endtask

    task automatic check_field(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: resp.%s expected %0h got %0h", $time, name, want, got);
            mismatch_count++;
        end
    endtask

    always @(posedge CLK) begin
        if (reset) begin
            for (int a = 0; a < 1024; a++) begin
                model_mem[a] = '0;
            end
            pending        = 1'b0;
            expected       = '0;
            mismatch_count = 0;
            other_count    = 0;
            resp_count     = 0;
        end else begin
            if (resp_valid) begin
                resp_count++;
                if (!pending) begin
                    $display("%0t: response arrived with no request outstanding", $time);
                    other_count++;
                end else begin
                    check_field("is_vector", resp.is_vector, expected.is_vector);
                    check_field("vd", resp.vd, expected.vd);
                    check_field("vwdata", resp.vwdata, expected.vwdata);
                    check_field("vbyte_wen", resp.vbyte_wen, expected.vbyte_wen);
                    check_field("reg_write", resp.reg_write, expected.reg_write);
                    check_field("rd", resp.rd, expected.rd);
                    check_field("rdata", resp.rdata, expected.rdata);
                    check_field("mal_addr", resp.mal_addr, expected.mal_addr);
                end
                pending = 1'b0;
            end
            if (req_valid && !busy) begin
                if (pending) begin
                    $display("%0t: request accepted before the previous response", $time);
                    other_count++;
                end
                run_model(req, expected);
                pending = 1'b1;
            end
        end
    end

endmodule

// ==== bench/vmem_stage_tb.sv ====
`timescale 1ns/1ps

module vmem_stage_tb;

    import vmem_pkg::*;

    localparam int num_ops    = 300;
    localparam int max_cycles = num_ops * 10;  // At most 7 cycles per op, plus margin

    logic        CLK;
    logic        reset;
    logic        req_valid;
    vmem_req_t   req;
    logic        busy;
    logic        resp_valid;
    vmem_resp_t  resp;
    vmem_req_t   next_req;
    logic [31:0] rng_state;
    int          mismatch_count;
    int          other_count;
    int          resp_count;
    int          cycle_count;
    int          bench_errors;
    int          assert_errors;

    vmem_stage u_dut (
        .CLK,
        .reset,
        .req_valid,
        .req,
        .busy,
        .resp_valid,
        .resp
    );

    vmem_stage_checker u_checker (
        .CLK,
        .reset,
        .req_valid,
        .req,
        .busy,
        .resp_valid,
        .resp,
        .mismatch_count,
        .other_count,
        .resp_count
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    task automatic make_request(output vmem_req_t r);
        logic [31:0] rnd;
        int          esize;
        r = '0;
        draw(rnd);
        r.is_vector = rnd[0];
        r.is_store  = rnd[1];
        r.eew       = eew_e'(2'(rnd[15:8] % 3));
        r.uop_num   = rnd[3:2];
        r.vstart    = rnd[4] ? rnd[19:16] : 4'd0;   // Mostly from element 0
        r.lane_mask = rnd[5] ? rnd[23:20] : 4'hf;
        r.vd        = rnd[28:24];
        draw(rnd);
        r.rd     = rnd[4:0];
        r.base   = rnd % 216;        // Last lane stays below byte 256
        r.stride = (rnd >> 8) % 13;
        esize    = 1 << int'(r.eew);
        draw(rnd);
        // One op in five keeps its raw, possibly misaligned address
        if (rnd % 5 != 0) begin
            r.base   = r.base & ~(32'(esize) - 32'd1);
            r.stride = r.stride & ~(32'(esize) - 32'd1);
        end
        for (int l = 0; l < num_lanes; l++) begin
            draw(rnd);
            r.store_data[l] = rnd;
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        next_req     = '0;
        rng_state    = 32'h9520_477f;
        bench_errors = 0;
        repeat (3) @(posedge CLK);
        reset <= 1'b0;
        @(posedge CLK);
        for (int n = 0; n < num_ops; n++) begin
            make_request(next_req);
            req_valid <= 1'b1;
            req       <= next_req;
            @(posedge CLK);
            req_valid <= 1'b0;
            @(posedge resp_valid);  // Next op goes out in the response cycle
        end
        repeat (2) @(posedge CLK);

        if (resp_count != num_ops) begin
            $display("wrong number of responses: %0d of %0d", resp_count, num_ops);
            bench_errors++;
        end
        assert_errors = u_dut.u_properties.fail_count;
        $display("errors: %0d mismatches, %0d checker, %0d assertion, %0d bench",
                 mismatch_count, other_count, assert_errors, bench_errors);
        if (mismatch_count + other_count + assert_errors + bench_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vmem_stage.f ====
source/vmem_pkg.sv
source/vmem_uop_decode.sv
source/vmem_serializer.sv
source/vmem_data_ram.sv
source/vmem_writeback.sv
source/vmem_stage.sv
bench/vmem_stage_properties.sv
bench/vmem_stage_checker.sv
bench/vmem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: vmem_stage

sources:
  - source/vmem_pkg.sv
  - source/vmem_uop_decode.sv
  - source/vmem_serializer.sv
  - source/vmem_data_ram.sv
  - source/vmem_writeback.sv
  - source/vmem_stage.sv
  - target: test
    files:
      - bench/vmem_stage_properties.sv
      - bench/vmem_stage_checker.sv
      - bench/vmem_stage_tb.sv
